// ==== files.f ====
dma_tc_pkg.sv
dma_tc_if.sv
dccm_store.sv
tc_decode.sv
xfer_execute.sv
xfer_result.sv
dma_tc_top.sv
dma_tc_props.sv
dma_tc_testcase_gen.sv
dma_tc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA test-case engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dma_tc_tb -f files.f -o dma_tc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/dma_tc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0

// ==== dma_tc_tb.sv ====
`timescale 1ns/1ns

module dma_tc_tb;

  localparam int ADDR_W = 8;

  logic                          clk;
  logic                          reset;
  logic                          load_en;
  logic [ADDR_W-1:0]             load_addr;
  logic [dma_tc_pkg::CODE_W-1:0] load_data;
  logic                          start;
  logic                          busy;
  logic                          done;
  logic                          wr_valid;
  logic [31:0]                   wr_addr;
  logic [31:0]                   wr_data;
  logic [31:0]                   tc_count;
  logic [31:0]                   ecc_corrected;
  logic                          ecc_fatal;

  logic [31:0] exp_a;
  logic [31:0] exp_d;
  logic        have_exp;

  dma_tc_top #(.ADDR_W(ADDR_W)) u_dma_tc_top (
    .clk           (clk),
    .reset         (reset),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .tc_count      (tc_count),
    .ecc_corrected (ecc_corrected),
    .ecc_fatal     (ecc_fatal)
  );

  dma_tc_testcase_gen #(.ADDR_W(ADDR_W)) u_gen (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  // ----------------------------------------------------------------------
  // Beat and run checks
  // ----------------------------------------------------------------------

  // Outputs are sampled half a cycle after they change
  always @(negedge clk) begin
    if (!reset && wr_valid) begin
      have_exp = u_gen.pop_expected(exp_a, exp_d);
      assert (have_exp) else fail_now("A write beat came out with none expected");
      assert (wr_addr == exp_a)
        else fail_now($sformatf("Error at %0t: wr_addr %h, expected %h", $time, wr_addr, exp_a));
      assert (wr_data == exp_d)
        else fail_now($sformatf("Error at %0t: wr_data %h, expected %h", $time, wr_data, exp_d));
    end
  end

  assert property (@(posedge clk) disable iff (reset) (start && !busy) |=> busy)
    else fail_now("busy did not rise the cycle after start");
  assert property (@(posedge clk) disable iff (reset) done |-> !busy)
    else fail_now("busy still high with done");

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
      else fail_now($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  // One full run with a stray start while busy
  task automatic run_case(input int mode);
    int limit;
    int cycles;
    u_gen.build_image(mode);
    limit = 4 * u_gen.image_words + 200;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value("busy", 32'(busy), 32'd1);
    cycles = 0;
    // Stray start lands once a test case has finished and beats have left
    while (tc_count == 32'd0) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        fail_now($sformatf("Run did not finish within %0d cycles", limit));
      end
    end
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        fail_now($sformatf("Run did not finish within %0d cycles", limit));
      end
    end while (!done);
    check_value("tc_count", tc_count, 32'(u_gen.exp_tc_count));
    check_value("beats left", 32'(u_gen.pending()), 32'd0);
    check_value("ecc_corrected", ecc_corrected, 32'(u_gen.exp_corrected));
    check_value("ecc_fatal", 32'(ecc_fatal), (mode == 2) ? 32'd1 : 32'd0);
    check_value("busy", 32'(busy), 32'd0);
  endtask

  // ----------------------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------------------

  initial begin
    reset = 1'b1;
    start = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("busy", 32'(busy), 32'd0);
    check_value("done", 32'(done), 32'd0);
    check_value("wr_valid", 32'(wr_valid), 32'd0);
    check_value("ecc_fatal", 32'(ecc_fatal), 32'd0);
    check_value("tc_count", tc_count, 32'd0);
    // Single flip in a payload word and then a double flip in a header
    run_case(1);
    run_case(2);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== dma_tc_testcase_gen.sv ====
`timescale 1ns/1ns

module dma_tc_testcase_gen #(
  parameter int ADDR_W = 8
) (
  input  logic                          clk,
  output logic                          load_en,
  output logic [ADDR_W-1:0]             load_addr,
  output logic [dma_tc_pkg::CODE_W-1:0] load_data
);
  import dma_tc_pkg::*;

  localparam int TOP_ADDR = (1 << ADDR_W) - 1;
  localparam int N_TC     = 6;

  integer      seed;
  logic [31:0] words[$];
  logic [31:0] exp_addr_q[$];
  logic [31:0] exp_data_q[$];
  int          exp_tc_count;
  int          exp_corrected;
  int          image_words;

  initial begin
    seed = 43673;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
  end

  // ----------------------------------------------------------------------
  // Image builder
  // ----------------------------------------------------------------------

  // Mode 0 is clean, 1 flips one bit of a payload word,
  // 2 flips two bits of the type word of test case 2
  task automatic build_image(input int mode);
    int                size;
    int                xt;
    int                flip_idx;
    int                bit_a;
    int                bit_b;
    logic [6:0]        flags;
    logic              fixed;
    logic [31:0]       dst;
    logic [31:0]       pay;
    logic [31:0]       exp_d;
    logic [CODE_W-1:0] cw;
    words.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    flip_idx = -1;
    // Count word sits at the top
    words.push_back(32'(N_TC));
    for (int t = 0; t < N_TC; t++) begin
      size = int'($unsigned($random(seed)) % 9);
      // Keep at least one payload word for the single flip
      if (t == 1 && size == 0) begin
        size = 1;
      end
      xt = int'($unsigned($random(seed)) % 3);
      flags = 7'($random(seed));
      // Flag order src, dst, rd_fixed, wr_fixed, delays, rst, block
      fixed = flags[3];
      dst = $random(seed);
      if (mode == 2 && t == 2) begin
        flip_idx = words.size();
      end
      words.push_back({23'd0, flags, 2'(xt)});
      words.push_back(32'(size));
      words.push_back($random(seed));
      words.push_back(dst);
      for (int i = 0; i < size; i++) begin
        pay = $random(seed);
        if (mode == 1 && t == 1 && i == 0) begin
          flip_idx = words.size();
        end
        words.push_back(pay);
        case (dma_xfer_type_e'(xt))
          XFER_ZERO:   exp_d = 32'd0;
          XFER_INVERT: exp_d = ~pay;
          default:     exp_d = pay;
        endcase
        // An aborted run never reaches test case 2 or later
        if (!(mode == 2 && t >= 2)) begin
          exp_addr_q.push_back(fixed ? dst : dst + 32'(4 * i));
          exp_data_q.push_back(exp_d);
        end
      end
    end
    exp_tc_count = (mode == 2) ? 2 : N_TC;
    exp_corrected = (mode == 1) ? 1 : 0;
    image_words = words.size();
    // Any one codeword bit, or any two distinct bits
    bit_a = int'($unsigned($random(seed)) % CODE_W);
    bit_b = (bit_a + 1 + int'($unsigned($random(seed)) % (CODE_W - 1))) % CODE_W;
    for (int k = 0; k < image_words; k++) begin
      cw = {ecc32_encode(words[k]), words[k]};
      if (k == flip_idx) begin
        cw[bit_a] = ~cw[bit_a];
        if (mode == 2) begin
          cw[bit_b] = ~cw[bit_b];
        end
      end
      @(posedge clk);
      load_en <= 1'b1;
      load_addr <= ADDR_W'(TOP_ADDR - k);
      load_data <= cw;
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Expected beat queue access
  // ----------------------------------------------------------------------

  function automatic logic pop_expected(output logic [31:0] a, output logic [31:0] d);
    a = '0;
    d = '0;
    if (exp_addr_q.size() == 0) begin
      return 1'b0;
    end
    a = exp_addr_q.pop_front();
    d = exp_data_q.pop_front();
    return 1'b1;
  endfunction

  function automatic int pending();
    return exp_addr_q.size();
  endfunction

endmodule

// ==== dma_tc_props.sv ====
`timescale 1ns/1ns

module dma_tc_props (
  input logic        clk,
  input logic        reset,
  input logic        start,
  input logic        busy,
  input logic        done,
  input logic        wr_valid,
  input logic        ecc_fatal,
  input logic [31:0] tc_count,
  input logic [31:0] ecc_corrected
);

  // ----------------------------------------------------------------------
  // Reset and run framing
  // ----------------------------------------------------------------------

  // Everything idle and cleared once reset is seen
  a_reset_idle: assert property (@(posedge clk)
    reset |=> (!busy && !done && !wr_valid && !ecc_fatal))
    else $error("outputs not idle after reset");

  a_reset_count: assert property (@(posedge clk)
    reset |=> (tc_count == 32'd0 && ecc_corrected == 32'd0))
    else $error("counters not cleared by reset");

  // busy only drops together with done
  a_busy_hold: assert property (@(posedge clk) disable iff (reset)
    busy |=> (busy || done))
    else $error("busy fell without done");

  // done is a single cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done held longer than one cycle");

  // Writes only inside a run
  a_wr_in_run: assert property (@(posedge clk) disable iff (reset)
    wr_valid |-> busy)
    else $error("write beat outside a run");

  // Fatal flag is sticky until an accepted start
  a_fatal_sticky: assert property (@(posedge clk) disable iff (reset)
    (ecc_fatal && !(start && !busy)) |=> ecc_fatal)
    else $error("ecc_fatal cleared without start");

endmodule

bind dma_tc_top dma_tc_props u_props (
  .clk           (clk),
  .reset         (reset),
  .start         (start),
  .busy          (busy),
  .done          (done),
  .wr_valid      (wr_valid),
  .ecc_fatal     (ecc_fatal),
  .tc_count      (tc_count),
  .ecc_corrected (ecc_corrected)
);

// ==== dma_tc_top.sv ====
`timescale 1ns/1ns

module dma_tc_top #(
  parameter int ADDR_W = 12
) (
  input  logic                          clk,
  input  logic                          reset,
  // Image load port
  input  logic                          load_en,
  input  logic [ADDR_W-1:0]             load_addr,
  input  logic [dma_tc_pkg::CODE_W-1:0] load_data,
  // Run control
  input  logic                          start,
  output logic                          busy,
  output logic                          done,
  // Destination write beats
  output logic                          wr_valid,
  output logic [31:0]                   wr_addr,
  output logic [31:0]                   wr_data,
  // Results
  output logic [31:0]                   tc_count,
  output logic [31:0]                   ecc_corrected,
  output logic                          ecc_fatal
);

  logic run_active;
  logic run_end;
  logic abort;
  logic tc_end;

  mem_rd_if #(.ADDR_W(ADDR_W)) rd_bus ();
  beat_if   #(.ADDR_W(ADDR_W)) beat_bus ();

  // ----------------------------------------------------------------------
  // Store, decode, execute, result
  // ----------------------------------------------------------------------

  dccm_store #(.ADDR_W(ADDR_W)) u_store (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd        (rd_bus.store)
  );

  tc_decode #(.ADDR_W(ADDR_W)) u_decode (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .rd         (rd_bus.reader),
    .beat       (beat_bus.src),
    .run_active (run_active),
    .run_end    (run_end),
    .abort      (abort)
  );

  xfer_execute u_execute (
    .clk      (clk),
    .reset    (reset),
    .beat     (beat_bus.sink),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .tc_end   (tc_end)
  );

  // ECC flags come straight off the read port
  xfer_result u_result (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .run_active    (run_active),
    .run_end       (run_end),
    .abort         (abort),
    .tc_end        (tc_end),
    .ecc_single    (rd_bus.ecc_single),
    .ecc_double    (rd_bus.ecc_double),
    .busy          (busy),
    .done          (done),
    .tc_count      (tc_count),
    .ecc_corrected (ecc_corrected),
    .ecc_fatal     (ecc_fatal)
  );

endmodule

// ==== xfer_result.sv ====
`timescale 1ns/1ns

module xfer_result (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic        run_active,
  input  logic        run_end,
  input  logic        abort,
  input  logic        tc_end,
  input  logic        ecc_single,
  input  logic        ecc_double,
  output logic        busy,
  output logic        done,
  output logic [31:0] tc_count,
  output logic [31:0] ecc_corrected,
  output logic        ecc_fatal
);

  logic accept;
  logic finish;

  // Start during a run is dropped
  assign accept = start & ~busy;
  assign finish = run_end | abort;

  // ----------------------------------------------------------------------
  // Run status and counters
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      tc_count <= '0;
      ecc_corrected <= '0;
      ecc_fatal <= 1'b0;
    end else begin
      // busy falls on the same edge done rises
      done <= finish;
      if (accept) begin
        busy <= 1'b1;
      end else if (finish) begin
        busy <= 1'b0;
      end
      if (accept) begin
        tc_count <= '0;
        ecc_corrected <= '0;
        ecc_fatal <= 1'b0;
      end else begin
        if (tc_end) begin
          tc_count <= tc_count + 32'd1;
        end
        // Corrected reads only count inside a run
        if (ecc_single && run_active) begin
          ecc_corrected <= ecc_corrected + 32'd1;
        end
        // Fatal holds until the next accepted start
        if (ecc_double) begin
          ecc_fatal <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== xfer_execute.sv ====
`timescale 1ns/1ns

module xfer_execute (
  input  logic        clk,
  input  logic        reset,
  beat_if.sink        beat,
  output logic        wr_valid,
  output logic [31:0] wr_addr,
  output logic [31:0] wr_data,
  output logic        tc_end
);
  import dma_tc_pkg::*;

  // A test case never holds more words than the store
  localparam int IDX_W = beat.ADDR_W;

  logic [IDX_W-1:0] idx_q;
  logic [IDX_W-1:0] cur_idx;
  logic [31:0]      byte_off;
  logic [31:0]      next_data;

  // ----------------------------------------------------------------------
  // Address and data shaping
  // ----------------------------------------------------------------------

  // Index restarts on the first beat of each test case
  assign cur_idx  = beat.first ? '0 : idx_q;
  assign byte_off = 32'(cur_idx) << 2;

  always_comb begin
    case (beat.xfer_type)
      XFER_ZERO:   next_data = '0;
      XFER_INVERT: next_data = ~beat.data;
      default:     next_data = beat.data;
    endcase
  end

  // ----------------------------------------------------------------------
  // Write beat registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_valid <= 1'b0;
      tc_end <= 1'b0;
      idx_q <= '0;
    end else begin
      wr_valid <= beat.valid;
      // Empty test cases close here too, with no write
      tc_end <= beat.last;
      if (beat.valid) begin
        idx_q <= cur_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat.valid) begin
      // Fixed mode keeps hitting the same address
      wr_addr <= beat.wr_fixed ? beat.dst_offset : beat.dst_offset + byte_off;
      wr_data <= next_data;
    end
  end

endmodule

// ==== tc_decode.sv ====
`timescale 1ns/1ns

module tc_decode #(
  parameter int ADDR_W = 12
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      start,
  mem_rd_if.reader  rd,
  beat_if.src       beat,
  output logic      run_active,
  output logic      run_end,
  output logic      abort
);
  import dma_tc_pkg::*;

  // FSM states
  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_REQ  = 3'd1;
  localparam logic [2:0] S_CAP  = 3'd2;
  localparam logic [2:0] S_END  = 3'd3;
  // Extra cycle so the run stays busy until done
  localparam logic [2:0] S_WAIT = 3'd4;

  // Which word of the image is being read
  localparam logic [2:0] F_COUNT = 3'd0;
  localparam logic [2:0] F_TYPE  = 3'd1;
  localparam logic [2:0] F_SIZE  = 3'd2;
  localparam logic [2:0] F_SRC   = 3'd3;
  localparam logic [2:0] F_DST   = 3'd4;
  localparam logic [2:0] F_PAY   = 3'd5;

  logic [2:0]        state_q;
  logic [2:0]        field_q;
  logic [2:0]        field_nxt;
  logic [ADDR_W-1:0] addr_q;
  logic [31:0]       tc_left_q;
  logic [31:0]       remain_q;
  logic              first_q;
  logic              aborted_q;
  xfer_type_word_t   type_q;
  logic [31:0]       dst_q;
  logic              read_more;
  logic              tc_done;

  // Beat registers
  logic              beat_valid_q;
  logic              beat_first_q;
  logic              beat_last_q;
  logic [31:0]       beat_data_q;
  logic              run_end_q;
  logic              abort_q;

  // ----------------------------------------------------------------------
  // Next word to read
  // ----------------------------------------------------------------------

  always_comb begin
    read_more = 1'b1;
    field_nxt = field_q;
    tc_done = 1'b0;
    case (field_q)
      F_COUNT: begin
        field_nxt = F_TYPE;
        // Empty image ends the run at once
        read_more = rd.rdata != '0;
      end
      F_TYPE:  field_nxt = F_SIZE;
      F_SIZE:  field_nxt = F_SRC;
      // Source offset is read and checked but not used
      F_SRC:   field_nxt = F_DST;
      F_DST: begin
        if (remain_q == '0) begin
          tc_done = 1'b1;
        end else begin
          field_nxt = F_PAY;
        end
      end
      default: tc_done = remain_q == 32'd1;
    endcase
    if (tc_done) begin
      field_nxt = F_TYPE;
      read_more = tc_left_q != 32'd1;
    end
  end

  // ----------------------------------------------------------------------
  // FSM and header capture
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    // Strobes default low
    beat_valid_q <= 1'b0;
    beat_first_q <= 1'b0;
    beat_last_q <= 1'b0;
    run_end_q <= 1'b0;
    abort_q <= 1'b0;
    if (reset) begin
      state_q <= S_IDLE;
      field_q <= F_COUNT;
      addr_q <= '0;
      tc_left_q <= '0;
      remain_q <= '0;
      first_q <= 1'b0;
      aborted_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start) begin
            // Count sits at the top word
            addr_q <= '1;
            field_q <= F_COUNT;
            aborted_q <= 1'b0;
            state_q <= S_REQ;
          end
        end
        S_REQ:  state_q <= S_CAP;
        S_CAP: begin
          if (rd.rvalid) begin
            if (rd.ecc_double) begin
              aborted_q <= 1'b1;
              state_q <= S_END;
            end else begin
              case (field_q)
                F_COUNT: tc_left_q <= rd.rdata;
                F_TYPE:  type_q <= xfer_type_word_t'(rd.rdata);
                F_SIZE:  remain_q <= rd.rdata;
                F_DST: begin
                  dst_q <= rd.rdata;
                  first_q <= 1'b1;
                  // Size 0 closes with a lone first and last
                  beat_first_q <= remain_q == '0;
                  beat_last_q <= remain_q == '0;
                end
                F_PAY: begin
                  beat_valid_q <= 1'b1;
                  beat_first_q <= first_q;
                  beat_last_q <= remain_q == 32'd1;
                  beat_data_q <= rd.rdata;
                  first_q <= 1'b0;
                  remain_q <= remain_q - 32'd1;
                end
                default: ;
              endcase
              if (tc_done) begin
                tc_left_q <= tc_left_q - 32'd1;
              end
              field_q <= field_nxt;
              if (!read_more) begin
                state_q <= S_END;
              end else if (addr_q == '0) begin
                // Image would run below address 0
                aborted_q <= 1'b1;
                state_q <= S_END;
              end else begin
                addr_q <= addr_q - 1'b1;
                state_q <= S_REQ;
              end
            end
          end
        end
        S_END: begin
          // Pulse lands after the last beat has left execute
          run_end_q <= ~aborted_q;
          abort_q <= aborted_q;
          state_q <= S_WAIT;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign rd.req  = state_q == S_REQ;
  assign rd.addr = addr_q;

  assign beat.valid      = beat_valid_q;
  assign beat.first      = beat_first_q;
  assign beat.last       = beat_last_q;
  assign beat.xfer_type  = type_q.dma_xfer_type;
  assign beat.wr_fixed   = type_q.use_wr_fixed;
  assign beat.dst_offset = dst_q;
  assign beat.data       = beat_data_q;

  assign run_active = state_q != S_IDLE;
  assign run_end    = run_end_q;
  assign abort      = abort_q;

endmodule

// ==== dccm_store.sv ====
`timescale 1ns/1ns

module dccm_store #(
  parameter int ADDR_W = 12
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load_en,
  input  logic [ADDR_W-1:0]             load_addr,
  input  logic [dma_tc_pkg::CODE_W-1:0] load_data,
  mem_rd_if.store                       rd
);
  import dma_tc_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;
  // Highest syndrome that still names a real codeword position
  localparam int LAST_POS = 38;

  // Codeword array, no reset on contents
  logic [CODE_W-1:0] mem [DEPTH];

  // Raw codeword captured on a read
  logic [CODE_W-1:0] rd_word_q;
  logic              rvalid_q;

  logic [ECC_W-1:0]  syndrome;
  logic [31:0]       fixed_data;
  logic              odd_flips;
  logic              pos_hit;
  logic              pos_bad;

  // ----------------------------------------------------------------------
  // Load and read
  // ----------------------------------------------------------------------

  // Generator writes whole codewords, only while the engine is idle
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.req) begin
      rd_word_q <= mem[rd.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd.req;
    end
  end

  // ----------------------------------------------------------------------
  // Check and correct on the way out
  // ----------------------------------------------------------------------

  always_comb begin
    fixed_data = ecc32_check(rd_word_q, syndrome);
  end

  assign odd_flips = syndrome[ECC_W-1];
  assign pos_hit   = |syndrome[ECC_W-2:0];
  // Odd parity pointing outside the codeword is three or more flips
  assign pos_bad   = int'(syndrome[ECC_W-2:0]) > LAST_POS;

  assign rd.rdata      = fixed_data;
  assign rd.rvalid     = rvalid_q;
  // Single flip, possibly in a check bit
  assign rd.ecc_single = rvalid_q & odd_flips & ~pos_bad;
  // Even parity with a nonzero syndrome is a double flip
  assign rd.ecc_double = rvalid_q & ((~odd_flips & pos_hit) | (odd_flips & pos_bad));

endmodule

// ==== dma_tc_if.sv ====
`timescale 1ns/1ns

// ----------------------------------------------------------------------
// Read port into the word store
// ----------------------------------------------------------------------
interface mem_rd_if #(
  parameter int ADDR_W = 12
) ();
  logic              req;
  logic [ADDR_W-1:0] addr;
  // Returned one cycle after req, already corrected
  logic [31:0]       rdata;
  logic              rvalid;
  // Error flags only mean something with rvalid
  logic              ecc_single;
  logic              ecc_double;

  modport reader (output req, addr,
                  input  rdata, rvalid, ecc_single, ecc_double);
  modport store  (input  req, addr,
                  output rdata, rvalid, ecc_single, ecc_double);
endinterface

// ----------------------------------------------------------------------
// Payload beats from decode to execute
// ----------------------------------------------------------------------
interface beat_if #(
  parameter int ADDR_W = 12
) ();
  // valid marks a data beat
  logic                       valid;
  // first and last bound a test case, last alone closes an empty one
  logic                       first;
  logic                       last;
  dma_tc_pkg::dma_xfer_type_e xfer_type;
  logic                       wr_fixed;
  logic [31:0]                dst_offset;
  logic [31:0]                data;

  modport src  (output valid, first, last, xfer_type, wr_fixed, dst_offset, data);
  modport sink (input  valid, first, last, xfer_type, wr_fixed, dst_offset, data);
endinterface

// ==== dma_tc_pkg.sv ====
package dma_tc_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Check bits per word, six Hamming bits plus overall parity
  localparam int ECC_W  = 7;
  // Stored codeword is {check, data}
  localparam int CODE_W = 32 + ECC_W;

  // ----------------------------------------------------------------------
  // Test-case type word
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    XFER_COPY   = 2'd0,
    XFER_ZERO   = 2'd1,
    XFER_INVERT = 2'd2
  } dma_xfer_type_e;

  // Only use_wr_fixed and dma_xfer_type steer the engine
  typedef struct packed {
    logic [22:0]    reserved;
    logic           src_is_fifo;
    logic           dst_is_fifo;
    logic           use_rd_fixed;
    logic           use_wr_fixed;
    logic           inject_rand_delays;
    logic           inject_rst;
    logic           test_block_size;
    dma_xfer_type_e dma_xfer_type;
  } xfer_type_word_t;

  // ----------------------------------------------------------------------
  // SECDED over 32 data bits
  // ----------------------------------------------------------------------

  // Data bits sit at the non power of two positions 3..38
  function automatic logic [ECC_W-1:0] ecc32_encode(input logic [31:0] data);
    logic [38:0]      pos;
    logic [ECC_W-1:0] chk;
    int unsigned      d;
    pos = '0;
    chk = '0;
    d = 0;
    for (int p = 1; p < 39; p++) begin
      if ((p & (p - 1)) != 0) begin
        pos[p] = data[d];
        d++;
      end
    end
    // Parity bit k covers every position with bit k set
    for (int k = 0; k < ECC_W - 1; k++) begin
      for (int p = 1; p < 39; p++) begin
        if ((p & (1 << k)) != 0) begin
          chk[k] = chk[k] ^ pos[p];
        end
      end
    end
    // Overall parity makes the whole codeword even
    chk[ECC_W-1] = ^{chk[ECC_W-2:0], data};
    return chk;
  endfunction

  // Returns corrected data; syndrome MSB set means an odd number of flips
  function automatic logic [31:0] ecc32_check(input logic [CODE_W-1:0] cw,
                                              output logic [ECC_W-1:0] syndrome);
    logic [31:0]      data;
    logic [ECC_W-1:0] chk;
    int unsigned      d;
    data = cw[31:0];
    chk = ecc32_encode(data);
    syndrome[ECC_W-2:0] = chk[ECC_W-2:0] ^ cw[CODE_W-2:32];
    syndrome[ECC_W-1] = ^cw;
    d = 0;
    // Flip the data bit that the syndrome points at
    for (int p = 1; p < 39; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (syndrome[ECC_W-1] && (int'(syndrome[ECC_W-2:0]) == p)) begin
          data[d] = ~data[d];
        end
        d++;
      end
    end
    return data;
  endfunction

endpackage
